// ==== logic/bram_test_pkg.sv ====
`default_nettype none

package bram_test_pkg;

    // RAM geometry under test
    localparam int ADDR_W = 6;
    localparam int DEPTH  = 64;
    localparam int DATA_W = 16;

    // Lane layout
    localparam int NUM_LANES = 4;
    localparam int LANE_W    = 2;

    // Index of the bit flipped by fault injection
    localparam int BIT_W = 4;

    // Phase 0 word is base plus address, phase 1 is its inverse
    localparam logic [DATA_W-1:0] PATTERN_BASE = 16'h5A00;

    // Report stream
    localparam int BYTE_W     = 8;
    localparam int BYTE_IDX_W = 3;

    // Lane index goes in the low bits of the tag
    localparam logic [BYTE_W-1:0] TAG_ERROR = 8'hE0;

    // Error-lane mask goes in the low bits of the summary
    localparam logic [BYTE_W-1:0] TAG_SUMMARY = 8'hA0;

    // Tag, address, expected hi/lo, actual hi/lo
    localparam int RECORD_BYTES = 6;

endpackage

`default_nettype wire

// ==== logic/dual_port_ram.sv ====
`default_nettype none

module dual_port_ram (
    input  logic                              clk,
    // Write port
    input  logic                              wr_en,
    input  logic [bram_test_pkg::ADDR_W-1:0]  wr_addr,
    input  logic [bram_test_pkg::DATA_W-1:0]  wr_data,
    // Read port
    input  logic                              rd_en,
    input  logic [bram_test_pkg::ADDR_W-1:0]  rd_addr,
    output logic [bram_test_pkg::DATA_W-1:0]  rd_data
);

    logic [bram_test_pkg::DATA_W-1:0] mem [bram_test_pkg::DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Registered read, one cycle latency
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

// ==== logic/pattern_sequencer.sv ====
`default_nettype none

module pattern_sequencer (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic                              start,
    input  logic                              busy,
    output logic                              run_clear,
    // Write broadcast
    output logic                              wr_en,
    output logic [bram_test_pkg::ADDR_W-1:0]  wr_addr,
    output logic [bram_test_pkg::DATA_W-1:0]  wr_data,
    // Read broadcast
    output logic                              rd_en,
    output logic [bram_test_pkg::ADDR_W-1:0]  rd_addr,
    output logic [bram_test_pkg::DATA_W-1:0]  rd_expected,
    output logic                              run_done
);

    typedef enum logic [1:0] {
        st_idle,
        st_write,
        st_read,
        st_drain
    } state_t;

    state_t                            state;
    logic                              phase;
    logic [bram_test_pkg::ADDR_W-1:0]  addr;
    logic [bram_test_pkg::DATA_W-1:0]  base_word;
    logic [bram_test_pkg::DATA_W-1:0]  pattern;
    logic                              last_addr;

    assign base_word = bram_test_pkg::PATTERN_BASE + bram_test_pkg::DATA_W'(addr);
    assign pattern   = phase ? ~base_word : base_word;
    assign last_addr = (addr == bram_test_pkg::ADDR_W'(bram_test_pkg::DEPTH - 1));

    // Writes and reads share one counter, never in the same cycle
    assign wr_en       = (state == st_write);
    assign wr_addr     = addr;
    assign wr_data     = pattern;
    assign rd_en       = (state == st_read);
    assign rd_addr     = addr;
    assign rd_expected = pattern;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= st_idle;
            phase     <= 1'b0;
            addr      <= '0;
            run_clear <= 1'b0;
            run_done  <= 1'b0;
        end else begin
            run_clear <= 1'b0;
            run_done  <= 1'b0;
            case (state)
                st_idle: begin
                    // busy already covers the run_clear cycle
                    if (run_clear) begin
                        state <= st_write;
                        phase <= 1'b0;
                        addr  <= '0;
                    end else if (start && !busy) begin
                        run_clear <= 1'b1;
                    end
                end
                st_write: begin
                    addr <= addr + 1'b1;
                    if (last_addr) begin
                        state <= st_read;
                    end
                end
                st_read: begin
                    addr <= addr + 1'b1;
                    if (last_addr) begin
                        if (phase) begin
                            state <= st_drain;
                        end else begin
                            phase <= 1'b1;
                            state <= st_write;
                        end
                    end
                end
                st_drain: begin
                    // Last compare lands in the lanes as run_done rises
                    run_done <= 1'b1;
                    state    <= st_idle;
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/bist_lane.sv ====
`default_nettype none

module bist_lane (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic                              run_clear,
    input  logic                              wr_en,
    input  logic [bram_test_pkg::ADDR_W-1:0]  wr_addr,
    input  logic [bram_test_pkg::DATA_W-1:0]  wr_data,
    input  logic                              rd_en,
    input  logic [bram_test_pkg::ADDR_W-1:0]  rd_addr,
    input  logic [bram_test_pkg::DATA_W-1:0]  rd_expected,
    input  logic                              run_done,
    // Fault injection
    input  logic                              inject,
    input  logic [bram_test_pkg::ADDR_W-1:0]  fault_addr,
    input  logic [bram_test_pkg::BIT_W-1:0]   fault_bit,
    // Record handshake to the reporter
    input  logic                              err_ack,
    output logic                              err_req,
    output logic [bram_test_pkg::ADDR_W-1:0]  err_addr,
    output logic [bram_test_pkg::DATA_W-1:0]  err_expected,
    output logic [bram_test_pkg::DATA_W-1:0]  err_actual
);

    logic [bram_test_pkg::DATA_W-1:0]  flip_mask;
    logic [bram_test_pkg::DATA_W-1:0]  ram_wr_data;
    logic [bram_test_pkg::DATA_W-1:0]  rd_data;
    logic                              rd_en_d;
    logic [bram_test_pkg::ADDR_W-1:0]  rd_addr_d;
    logic [bram_test_pkg::DATA_W-1:0]  rd_expected_d;
    logic                              mismatch;
    logic                              err_flag;

    // Flip one bit on the way into the RAM
    assign flip_mask = (inject && (wr_addr == fault_addr))
                     ? (bram_test_pkg::DATA_W'(1) << fault_bit) : '0;
    assign ram_wr_data = wr_data ^ flip_mask;

    dual_port_ram dual_port_ram_i (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (ram_wr_data),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    // Align address and expected word with the RAM output
    always_ff @(posedge clk) begin
        rd_addr_d     <= rd_addr;
        rd_expected_d <= rd_expected;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_en_d <= 1'b0;
        end else begin
            rd_en_d <= rd_en;
        end
    end

    assign mismatch = rd_en_d && (rd_data != rd_expected_d);

    // First mismatch only
    always_ff @(posedge clk) begin
        if (mismatch && !err_flag) begin
            err_addr     <= rd_addr_d;
            err_expected <= rd_expected_d;
            err_actual   <= rd_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            err_flag <= 1'b0;
            err_req  <= 1'b0;
        end else begin
            if (run_clear) begin
                err_flag <= 1'b0;
            end else if (mismatch) begin
                err_flag <= 1'b1;
            end
            // Request held until the reporter acknowledges
            if (run_done && err_flag) begin
                err_req <= 1'b1;
            end else if (err_ack) begin
                err_req <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/error_reporter.sv ====
`default_nettype none

module error_reporter (
    input  logic                                                   clk,
    input  logic                                                   arst_n,
    input  logic                                                   run_clear,
    input  logic                                                   run_done,
    // Lane records
    input  logic [bram_test_pkg::NUM_LANES-1:0]                    err_req,
    input  logic [bram_test_pkg::NUM_LANES-1:0][bram_test_pkg::ADDR_W-1:0] err_addr,
    input  logic [bram_test_pkg::NUM_LANES-1:0][bram_test_pkg::DATA_W-1:0] err_expected,
    input  logic [bram_test_pkg::NUM_LANES-1:0][bram_test_pkg::DATA_W-1:0] err_actual,
    output logic [bram_test_pkg::NUM_LANES-1:0]                    err_ack,
    output logic                                                   busy,
    // Byte stream
    input  logic                                                   out_ack,
    output logic                                                   out_req,
    output logic [bram_test_pkg::BYTE_W-1:0]                       out_data
);

    typedef enum logic [2:0] {
        st_idle,
        st_scan,
        st_send,
        st_summary,
        st_finish
    } state_t;

    state_t                                state;
    logic                                  busy_r;
    logic [bram_test_pkg::LANE_W-1:0]      lane;
    logic [bram_test_pkg::BYTE_IDX_W-1:0]  byte_idx;
    logic [bram_test_pkg::NUM_LANES-1:0]   err_mask;
    logic [bram_test_pkg::ADDR_W-1:0]      rec_addr;
    logic [bram_test_pkg::DATA_W-1:0]      rec_expected;
    logic [bram_test_pkg::DATA_W-1:0]      rec_actual;
    logic [bram_test_pkg::BYTE_W-1:0]      tx_byte;
    logic                                  hs_load;
    logic                                  hs_done;
    logic                                  last_lane;
    logic                                  last_byte;

    assign busy = busy_r | run_clear;

    assign hs_load   = !out_req && !out_ack;
    assign hs_done   = out_req && out_ack;
    assign last_lane = (lane == bram_test_pkg::LANE_W'(bram_test_pkg::NUM_LANES - 1));
    assign last_byte = (byte_idx == bram_test_pkg::BYTE_IDX_W'(bram_test_pkg::RECORD_BYTES - 1));

    always_comb begin
        if (state == st_summary) begin
            tx_byte = bram_test_pkg::TAG_SUMMARY | bram_test_pkg::BYTE_W'(err_mask);
        end else begin
            case (byte_idx)
                3'd0:    tx_byte = bram_test_pkg::TAG_ERROR | bram_test_pkg::BYTE_W'(lane);
                3'd1:    tx_byte = bram_test_pkg::BYTE_W'(rec_addr);
                3'd2:    tx_byte = rec_expected[bram_test_pkg::DATA_W-1:bram_test_pkg::BYTE_W];
                3'd3:    tx_byte = rec_expected[bram_test_pkg::BYTE_W-1:0];
                3'd4:    tx_byte = rec_actual[bram_test_pkg::DATA_W-1:bram_test_pkg::BYTE_W];
                default: tx_byte = rec_actual[bram_test_pkg::BYTE_W-1:0];
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_scan && err_req[lane]) begin
            rec_addr     <= err_addr[lane];
            rec_expected <= err_expected[lane];
            rec_actual   <= err_actual[lane];
        end
        if ((state == st_send || state == st_summary) && hs_load) begin
            out_data <= tx_byte;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= st_idle;
            busy_r   <= 1'b0;
            lane     <= '0;
            byte_idx <= '0;
            err_mask <= '0;
            err_ack  <= '0;
            out_req  <= 1'b0;
        end else begin
            // Ack drops once its lane has dropped the request
            err_ack <= err_ack & err_req;
            if (run_clear) begin
                busy_r   <= 1'b1;
                err_mask <= '0;
            end
            case (state)
                st_idle: begin
                    if (run_done) begin
                        lane     <= '0;
                        byte_idx <= '0;
                        state    <= st_scan;
                    end
                end
                st_scan: begin
                    if (err_req[lane]) begin
                        err_ack[lane]  <= 1'b1;
                        err_mask[lane] <= 1'b1;
                        byte_idx       <= '0;
                        state          <= st_send;
                    end else if (last_lane) begin
                        state <= st_summary;
                    end else begin
                        lane <= lane + 1'b1;
                    end
                end
                st_send: begin
                    if (hs_load) begin
                        out_req <= 1'b1;
                    end else if (hs_done) begin
                        out_req <= 1'b0;
                        if (!last_byte) begin
                            byte_idx <= byte_idx + 1'b1;
                        end else if (last_lane) begin
                            state <= st_summary;
                        end else begin
                            lane  <= lane + 1'b1;
                            state <= st_scan;
                        end
                    end
                end
                st_summary: begin
                    if (hs_load) begin
                        out_req <= 1'b1;
                    end else if (hs_done) begin
                        out_req <= 1'b0;
                        state   <= st_finish;
                    end
                end
                st_finish: begin
                    if (!out_ack) begin
                        busy_r <= 1'b0;
                        state  <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/bram_test_top.sv ====
`default_nettype none

module bram_test_top (
    input  logic                                 clk,
    input  logic                                 arst_n,
    input  logic                                 start,
    input  logic [bram_test_pkg::NUM_LANES-1:0]  fault_lanes,
    input  logic [bram_test_pkg::ADDR_W-1:0]     fault_addr,
    input  logic [bram_test_pkg::BIT_W-1:0]      fault_bit,
    input  logic                                 out_ack,
    output logic                                 busy,
    output logic                                 out_req,
    output logic [bram_test_pkg::BYTE_W-1:0]     out_data
);

    // Sequencer broadcast
    logic                              run_clear;
    logic                              run_done;
    logic                              wr_en;
    logic [bram_test_pkg::ADDR_W-1:0]  wr_addr;
    logic [bram_test_pkg::DATA_W-1:0]  wr_data;
    logic                              rd_en;
    logic [bram_test_pkg::ADDR_W-1:0]  rd_addr;
    logic [bram_test_pkg::DATA_W-1:0]  rd_expected;

    // Per-lane error records
    logic [bram_test_pkg::NUM_LANES-1:0]                            err_req;
    logic [bram_test_pkg::NUM_LANES-1:0]                            err_ack;
    logic [bram_test_pkg::NUM_LANES-1:0][bram_test_pkg::ADDR_W-1:0] err_addr;
    logic [bram_test_pkg::NUM_LANES-1:0][bram_test_pkg::DATA_W-1:0] err_expected;
    logic [bram_test_pkg::NUM_LANES-1:0][bram_test_pkg::DATA_W-1:0] err_actual;

    pattern_sequencer pattern_sequencer_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .start       (start),
        .busy        (busy),
        .run_clear   (run_clear),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .rd_en       (rd_en),
        .rd_addr     (rd_addr),
        .rd_expected (rd_expected),
        .run_done    (run_done)
    );

    for (genvar i = 0; i < bram_test_pkg::NUM_LANES; i++) begin : g_lane
        bist_lane bist_lane_i (
            .clk          (clk),
            .arst_n       (arst_n),
            .run_clear    (run_clear),
            .wr_en        (wr_en),
            .wr_addr      (wr_addr),
            .wr_data      (wr_data),
            .rd_en        (rd_en),
            .rd_addr      (rd_addr),
            .rd_expected  (rd_expected),
            .run_done     (run_done),
            .inject       (fault_lanes[i]),
            .fault_addr   (fault_addr),
            .fault_bit    (fault_bit),
            .err_ack      (err_ack[i]),
            .err_req      (err_req[i]),
            .err_addr     (err_addr[i]),
            .err_expected (err_expected[i]),
            .err_actual   (err_actual[i])
        );
    end

    error_reporter error_reporter_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .run_clear    (run_clear),
        .run_done     (run_done),
        .err_req      (err_req),
        .err_addr     (err_addr),
        .err_expected (err_expected),
        .err_actual   (err_actual),
        .err_ack      (err_ack),
        .busy         (busy),
        .out_ack      (out_ack),
        .out_req      (out_req),
        .out_data     (out_data)
    );

endmodule

`default_nettype wire

// ==== bench/bram_test_sva.sv ====
`default_nettype none

module bram_test_sva (
    input logic                                 clk,
    input logic                                 arst_n,
    input logic                                 busy,
    input logic                                 out_req,
    input logic                                 out_ack,
    input logic [bram_test_pkg::BYTE_W-1:0]     out_data,
    input logic [bram_test_pkg::NUM_LANES-1:0]  err_req,
    input logic [bram_test_pkg::NUM_LANES-1:0]  err_ack
);

    timeunit 1ns;
    timeprecision 1ps;

    // Byte held until the consumer acknowledges
    data_stable: assert property (@(posedge clk) disable iff (!arst_n)
        (out_req && !out_ack) |=> $stable(out_data))
        else $error("out_data changed while out_req waits for out_ack");

    req_held: assert property (@(posedge clk) disable iff (!arst_n)
        (out_req && !out_ack) |=> out_req)
        else $error("out_req fell before out_ack rose");

    reset_quiet: assert property (@(posedge clk)
        !arst_n |-> (!busy && !out_req && err_req == '0 && err_ack == '0))
        else $error("handshake or busy high while in reset");

endmodule

bind bram_test_top bram_test_sva bram_test_sva_i (
    .clk      (clk),
    .arst_n   (arst_n),
    .busy     (busy),
    .out_req  (out_req),
    .out_ack  (out_ack),
    .out_data (out_data),
    .err_req  (err_req),
    .err_ack  (err_ack)
);

`default_nettype wire

// ==== bench/bram_test_tb.sv ====
`default_nettype none

module bram_test_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int ADDR_W    = bram_test_pkg::ADDR_W;
    localparam int DATA_W    = bram_test_pkg::DATA_W;
    localparam int NUM_LANES = bram_test_pkg::NUM_LANES;
    localparam int BIT_W     = bram_test_pkg::BIT_W;
    localparam int BYTE_W    = bram_test_pkg::BYTE_W;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 8;
    localparam int DRIVE_DELAY  = 2;
    localparam int NUM_CASES    = 5;
    localparam int MAX_BYTES    = NUM_LANES * bram_test_pkg::RECORD_BYTES + 1;
    localparam int CASE_CYCLES  = 300 + MAX_BYTES * 12;
    // One extra slot for the reset-during-run check
    localparam int WATCHDOG_CYCLES = (NUM_CASES + 1) * CASE_CYCLES + RESET_CYCLES;
    localparam logic [31:0] SEED   = 32'h95808eea;

    logic                  clk;
    logic                  arst_n;
    logic                  start;
    logic [NUM_LANES-1:0]  fault_lanes;
    logic [ADDR_W-1:0]     fault_addr;
    logic [BIT_W-1:0]      fault_bit;
    logic                  out_ack;
    logic                  busy;
    logic                  out_req;
    logic [BYTE_W-1:0]     out_data;

    logic [BYTE_W-1:0] rx_bytes [$];
    logic [BYTE_W-1:0] exp_bytes [$];
    int                errors;

    // Fault cases; the last one also pulses start while the run is going
    string                case_name [NUM_CASES] = '{"no_fault", "lane0_addr0_bit0",
                                                    "lanes13_addr63_bit15",
                                                    "all_lanes_addr17_bit7",
                                                    "restart_ignored"};
    logic [NUM_LANES-1:0] case_lanes [NUM_CASES] = '{4'b0000, 4'b0001, 4'b1010, 4'b1111,
                                                     4'b0100};
    logic [ADDR_W-1:0]    case_addr [NUM_CASES] = '{6'd0, 6'd0, 6'd63, 6'd17, 6'd42};
    logic [BIT_W-1:0]     case_bit [NUM_CASES] = '{4'd0, 4'd0, 4'd15, 4'd7, 4'd9};
    logic                 case_restart [NUM_CASES] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1};

    bram_test_top bram_test_top_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .start       (start),
        .fault_lanes (fault_lanes),
        .fault_addr  (fault_addr),
        .fault_bit   (fault_bit),
        .out_ack     (out_ack),
        .busy        (busy),
        .out_req     (out_req),
        .out_data    (out_data)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_byte(input string name, input logic [BYTE_W-1:0] expected,
                              input logic [BYTE_W-1:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("error %s: expected %02h, actual %02h", name, expected, actual);
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (actual != expected) begin
            errors++;
            $display("error %s byte count: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            errors++;
            $display("error %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic pulse_start();
        start = 1'b1;
        next_cycle();
        start = 1'b0;
    endtask

    task automatic wait_busy(input logic level);
        do begin
            next_cycle();
        end while (busy !== level);
    endtask

    // Records in lane order, then the summary with the lane mask
    task automatic build_expected(input logic [NUM_LANES-1:0] lanes,
                                  input logic [ADDR_W-1:0] addr,
                                  input logic [BIT_W-1:0] bit_idx);
        logic [DATA_W-1:0] exp_word;
        logic [DATA_W-1:0] act_word;
        exp_bytes.delete();
        exp_word = bram_test_pkg::PATTERN_BASE + DATA_W'(addr);
        act_word = exp_word ^ (DATA_W'(1) << bit_idx);
        for (int l = 0; l < NUM_LANES; l++) begin
            if (lanes[l]) begin
                exp_bytes.push_back(bram_test_pkg::TAG_ERROR | BYTE_W'(l));
                exp_bytes.push_back(BYTE_W'(addr));
                exp_bytes.push_back(exp_word[15:8]);
                exp_bytes.push_back(exp_word[7:0]);
                exp_bytes.push_back(act_word[15:8]);
                exp_bytes.push_back(act_word[7:0]);
            end
        end
        exp_bytes.push_back(bram_test_pkg::TAG_SUMMARY | BYTE_W'(lanes));
    endtask

    task automatic run_case(input int idx);
        int n;
        fault_lanes = case_lanes[idx];
        fault_addr  = case_addr[idx];
        fault_bit   = case_bit[idx];
        build_expected(case_lanes[idx], case_addr[idx], case_bit[idx]);
        rx_bytes.delete();
        pulse_start();
        wait_busy(1'b1);
        if (case_restart[idx]) begin
            // Once during the pattern run, once while the reporter streams
            repeat (100) next_cycle();
            pulse_start();
            do begin
                next_cycle();
            end while (out_req !== 1'b1);
            pulse_start();
        end
        wait_busy(1'b0);
        // Summary byte already taken when busy falls
        check_count({case_name[idx], " at busy fall"}, exp_bytes.size(), rx_bytes.size());
        repeat (10) next_cycle();
        check_bit({case_name[idx], " busy"}, 1'b0, busy);
        check_count(case_name[idx], exp_bytes.size(), rx_bytes.size());
        n = (rx_bytes.size() < exp_bytes.size()) ? rx_bytes.size() : exp_bytes.size();
        for (int k = 0; k < n; k++) begin
            check_byte($sformatf("%s byte %0d", case_name[idx], k), exp_bytes[k], rx_bytes[k]);
        end
    endtask

    task automatic reset_mid_run();
        fault_lanes = 4'b1111;
        fault_addr  = 6'd3;
        fault_bit   = 4'd2;
        rx_bytes.delete();
        pulse_start();
        wait_busy(1'b1);
        repeat (50) next_cycle();
        arst_n = 1'b0;
        next_cycle();
        check_bit("reset_mid_run busy", 1'b0, busy);
        check_bit("reset_mid_run out_req", 1'b0, out_req);
        repeat (RESET_CYCLES) next_cycle();
        arst_n = 1'b1;
        repeat (300) next_cycle();
        check_bit("after_reset_mid_run busy", 1'b0, busy);
        check_count("reset_mid_run", 0, rx_bytes.size());
    endtask

    // Byte consumer with random ack delay
    initial begin : consumer
        int unsigned delay;
        out_ack = 1'b0;
        void'($urandom(SEED));
        forever begin
            next_cycle();
            if (out_req === 1'b1 && out_ack === 1'b0) begin
                rx_bytes.push_back(out_data);
                delay = $urandom_range(5, 0);
                repeat (delay) next_cycle();
                out_ack = 1'b1;
                do begin
                    next_cycle();
                end while (out_req !== 1'b0);
                out_ack = 1'b0;
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin : main
        errors      = 0;
        arst_n      = 1'b1;
        start       = 1'b0;
        fault_lanes = '0;
        fault_addr  = '0;
        fault_bit   = '0;
        #DRIVE_DELAY;
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        check_bit("in_reset busy", 1'b0, busy);
        arst_n = 1'b1;
        next_cycle();
        check_bit("after_reset busy", 1'b0, busy);
        for (int i = 0; i < NUM_CASES; i++) begin
            run_case(i);
        end
        reset_mid_run();
        $display("Tests run: %0d, errors: %0d", NUM_CASES + 1, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
logic/bram_test_pkg.sv
logic/dual_port_ram.sv
logic/pattern_sequencer.sv
logic/bist_lane.sv
logic/error_reporter.sv
logic/bram_test_top.sv
bench/bram_test_sva.sv
bench/bram_test_tb.sv
